//--- list.f
+incdir+tests
src/decodePkg.sv
src/decOp16.sv
src/decOp32.sv
src/decOp48.sv
src/decOp.sv
src/decodeStage.sv
tests/decodeTb.sv

//--- run.sh
#!/bin/sh
# build and run the decode stage testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module decodeTb -f list.f -o decodeSim
./obj_dir/decodeSim

//--- src/decOp.sv
// Instruction class decode and field select
`timescale 1ns/1ps
`default_nettype none

module decOp import decodePkg::*;
(
	input  wire logic [63:0]    istrWord,	// current window
	input  wire logic [63:0]    istrWordL,	// previously accepted window
	output logic [regWidth-1:0] idRegN,
	output logic [regWidth-1:0] idRegM,
	output logic [regWidth-1:0] idRegO,
	output logic [immWidth-1:0] idImm,
	output logic [immWidth-1:0] idImmB,
	output logic [cmdWidth-1:0] idUCmd,
	output logic [cmdWidth-1:0] idUIxt,
	output lenWords             idLen
);

	// jumbo prefix from last window
	logic                  jumboA;
	logic                  jumboB;
	logic [jumboWidth-1:0] jumboLo;
	logic [jumboWidth-1:0] jumboHi;

	assign jumboA  = (istrWordL[15:8] == jumboTag);
	assign jumboB  = jumboA && (istrWordL[47:40] == jumboTag);
	assign jumboLo = {istrWordL[7:0], istrWordL[31:16]};
	assign jumboHi = {istrWordL[39:32], istrWordL[63:48]};

	logic [regWidth-1:0] d16RegN, d16RegM, d16RegO;
	logic [immWidth-1:0] d16Imm;
	logic [cmdWidth-1:0] d16UCmd, d16Ixt;

	logic [regWidth-1:0] d32RegN, d32RegM, d32RegO;
	logic [immWidth-1:0] d32Imm, d32ImmB;
	logic [cmdWidth-1:0] d32UCmd, d32Ixt;

	logic [regWidth-1:0] d48RegN, d48RegM, d48RegO;
	logic [immWidth-1:0] d48Imm;
	logic [cmdWidth-1:0] d48UCmd, d48Ixt;

	decOp16 i_decOp16 (
		.istrWord (istrWord[15:0]),
		.regN     (d16RegN),
		.regM     (d16RegM),
		.regO     (d16RegO),
		.imm      (d16Imm),
		.ucmd     (d16UCmd),
		.ixt      (d16Ixt)
	);

	decOp32 i_decOp32 (
		.istrWord (istrWord[31:0]),
		.jumboLo  (jumboLo),
		.jumboHi  (jumboHi),
		.jumboA   (jumboA),
		.jumboB   (jumboB),
		.regN     (d32RegN),
		.regM     (d32RegM),
		.regO     (d32RegO),
		.imm      (d32Imm),
		.immB     (d32ImmB),
		.ucmd     (d32UCmd),
		.ixt      (d32Ixt)
	);

	decOp48 i_decOp48 (
		.istrWord (istrWord[47:0]),
		.regN     (d48RegN),
		.regM     (d48RegM),
		.regO     (d48RegO),
		.imm      (d48Imm),
		.ucmd     (d48UCmd),
		.ixt      (d48Ixt)
	);

	logic isDz;	// predicated class
	logic isDf;	// predicate-false when set

	always_comb
	begin
		idLen = len16;
		isDz  = 1'b0;
		isDf  = 1'b0;

		casez (istrWord[15:10])
			clsE0: begin idLen = len32; isDz = 1'b1; isDf = istrWord[10]; end
			clsE8: begin idLen = len32; isDz = 1'b1; isDf = istrWord[8]; end
			clsEC: begin idLen = len48; isDz = 1'b1; isDf = istrWord[9]; end
			clsF0,
			clsF8: idLen = len32;
			clsFC: idLen = len48;
			default: idLen = len16;
		endcase

		idImmB = '0;	// only the 32-bit form carries a second immediate
		case (idLen)
			len32:
			begin
				idRegN = d32RegN;
				idRegM = d32RegM;
				idRegO = d32RegO;
				idImm  = d32Imm;
				idImmB = d32ImmB;
				idUCmd = d32UCmd;
				idUIxt = d32Ixt;
			end
			len48:
			begin
				idRegN = d48RegN;
				idRegM = d48RegM;
				idRegO = d48RegO;
				idImm  = d48Imm;
				idUCmd = d48UCmd;
				idUIxt = d48Ixt;
			end
			default:
			begin
				idRegN = d16RegN;
				idRegM = d16RegM;
				idRegO = d16RegO;
				idImm  = d16Imm;
				idUCmd = d16UCmd;
				idUIxt = d16Ixt;
			end
		endcase

		if (isDz)
			idUCmd[7:6] = isDf ? condFalse : condTrue;

		// bad extension pair, keep the condition bits
		if (idUIxt[7:6] == ixtWideBad)
			idUCmd[5:0] = ucmdInvop;
	end

endmodule

`default_nettype wire

//--- src/decOp16.sv
// 16-bit instruction decoder
`timescale 1ns/1ps
`default_nettype none

module decOp16 import decodePkg::*;
(
	input  wire logic [15:0]         istrWord,
	output logic [regWidth-1:0]      regN,
	output logic [regWidth-1:0]      regM,
	output logic [regWidth-1:0]      regO,
	output logic [immWidth-1:0]      imm,
	output logic [cmdWidth-1:0]      ucmd,
	output logic [cmdWidth-1:0]      ixt
);

	logic [3:0] opNib;	// major op, top nibble
	logic [3:0] fldN;
	logic [3:0] fldM;
	logic [3:0] fldI;

	// nibble split of the single word
	assign opNib = istrWord[15:12];
	assign fldN  = istrWord[11:8];
	assign fldM  = istrWord[7:4];
	assign fldI  = istrWord[3:0];

	// short form only reaches the low 16 registers
	assign regN = {{(regWidth-4){1'b0}}, fldN};
	assign regM = {{(regWidth-4){1'b0}}, fldM};
	assign regO = '0;	// no third operand

	// 4-bit unsigned immediate
	assign imm = {{(immWidth-4){1'b0}}, fldI};

	// never predicated
	assign ucmd = {condAlways, grp16, opNib};

	assign ixt = '0;	// no extension byte in short ops

endmodule

`default_nettype wire

//--- src/decOp32.sv
// 32-bit instruction decoder
// with jumbo immediate merge
`timescale 1ns/1ps
`default_nettype none

module decOp32 import decodePkg::*;
(
	input  wire logic [31:0]           istrWord,
	input  wire logic [jumboWidth-1:0] jumboLo,
	input  wire logic [jumboWidth-1:0] jumboHi,
	input  wire logic                  jumboA,
	input  wire logic                  jumboB,
	output logic [regWidth-1:0]        regN,
	output logic [regWidth-1:0]        regM,
	output logic [regWidth-1:0]        regO,
	output logic [immWidth-1:0]        imm,
	output logic [immWidth-1:0]        immB,
	output logic [cmdWidth-1:0]        ucmd,
	output logic [cmdWidth-1:0]        ixt
);

	logic [15:0] wordA;	// first word
	logic [15:0] wordB;	// second word
	logic [9:0]  immRaw;
	logic [immWidth-1:0] immPlain;
	logic [immWidth-1:0] immJumbo;
	logic [immWidth-1:0] immWide;

	assign wordA = istrWord[15:0];
	assign wordB = istrWord[31:16];

	// register fields live in the second word
	assign regN = wordB[5:0];
	assign regM = wordB[11:6];

	// two high bits of the third register sit in the first word
	assign regO = {wordA[9:8], wordB[15:12]};

	// 10-bit signed immediate overlaps regM
	assign immRaw   = istrWord[31:22];
	assign immPlain = {{(immWidth-10){immRaw[9]}}, immRaw};

	/*
	 * Prefix A supplies 24 upper bits, the op keeps its top 8 bits as
	 * the low byte. The prefix top bit doubles as the sign.
	 */
	assign immJumbo = {jumboLo[jumboWidth-1], jumboLo, istrWord[31:24]};

	// prefix B adds a second immediate from the high half of the window
	assign immWide = {1'b0, jumboHi, jumboLo[23:16]};

	always_comb
	begin
		if (jumboA)
			imm = immJumbo;
		else
			imm = immPlain;

		if (jumboB)
			immB = immWide;
		else
			immB = '0;
	end

	// condition gets overridden upstream for predicated classes
	assign ucmd = {condAlways, grp32, wordA[3:0]};

	assign ixt = wordA[7:0];	// raw extension byte, checked in decOp

endmodule

`default_nettype wire

//--- src/decOp48.sv
// 48-bit instruction decoder
`timescale 1ns/1ps
`default_nettype none

module decOp48 import decodePkg::*;
(
	input  wire logic [47:0]    istrWord,
	output logic [regWidth-1:0] regN,
	output logic [regWidth-1:0] regM,
	output logic [regWidth-1:0] regO,
	output logic [immWidth-1:0] imm,
	output logic [cmdWidth-1:0] ucmd,
	output logic [cmdWidth-1:0] ixt
);

	logic [25:0] immRaw;	// spans words two and three

	assign regN = istrWord[21:16];
	assign regM = istrWord[27:22];
	assign regO = '0;

	assign immRaw = istrWord[47:22];
	assign imm    = {{(immWidth-26){immRaw[25]}}, immRaw};	// sign extend

	assign ucmd = {condAlways, grp48, istrWord[3:0]};

	// top pair always clear here, so never flagged bad
	assign ixt = {2'b00, istrWord[9:4]};

endmodule

`default_nettype wire

//--- src/decodePkg.sv
// Decode stage shared definitions
`default_nettype none

package decodePkg;

	// field widths
	localparam int regWidth   = 6;
	localparam int immWidth   = 33;
	localparam int cmdWidth   = 8;
	localparam int jumboWidth = 24;	// payload bits carried by one jumbo prefix

	// instruction length in 16-bit words
	typedef logic [1:0] lenWords;

	localparam lenWords len16 = 2'd1;
	localparam lenWords len32 = 2'd2;
	localparam lenWords len48 = 2'd3;

	// condition field, ucmd bits 7:6
	localparam logic [1:0] condAlways = 2'b00;
	localparam logic [1:0] condTrue   = 2'b10;	// run if predicate set
	localparam logic [1:0] condFalse  = 2'b11;	// run if predicate clear

	// extension top bits that no decoder may emit
	localparam logic [1:0] ixtWideBad = 2'b11;

	// invalid-op micro-command, low six bits of ucmd
	localparam logic [5:0] ucmdInvop = 6'h3F;

	// high byte of the first word in a jumbo prefix
	localparam logic [7:0] jumboTag = 8'hFE;

	// group bits, ucmd bits 5:4
	localparam logic [1:0] grp16 = 2'b00;
	localparam logic [1:0] grp32 = 2'b01;
	localparam logic [1:0] grp48 = 2'b10;

	/*
	 * Class prefixes on first word bits 15:10
	 *   11100x  E0..E7  32-bit predicated, df in bit 10
	 *   111010  E8..EB  32-bit predicated, df in bit 8
	 *   111011  EC..EF  48-bit predicated, df in bit 9
	 *   11110x  F0..F7  32-bit
	 *   111110  F8..FB  32-bit
	 *   111111  FC..FF  48-bit
	 * anything else is a 16-bit op
	 */
	localparam logic [5:0] clsE0 = 6'b11100?;
	localparam logic [5:0] clsE8 = 6'b111010;
	localparam logic [5:0] clsEC = 6'b111011;
	localparam logic [5:0] clsF0 = 6'b11110?;
	localparam logic [5:0] clsF8 = 6'b111110;
	localparam logic [5:0] clsFC = 6'b111111;

endpackage

`default_nettype wire

//--- src/decodeStage.sv
// Decode stage top
`timescale 1ns/1ps
`default_nettype none

module decodeStage import decodePkg::*;
(
	input  wire logic           clock,
	input  wire logic           rst,
	input  wire logic           istrValid,
	input  wire logic [63:0]    istrWord,
	output logic                opValid,
	output logic [regWidth-1:0] opRegN,
	output logic [regWidth-1:0] opRegM,
	output logic [regWidth-1:0] opRegO,
	output logic [immWidth-1:0] opImm,
	output logic [immWidth-1:0] opImmB,
	output logic [cmdWidth-1:0] opUCmd,
	output logic [cmdWidth-1:0] opUIxt,
	output lenWords             opLen
);

	logic [63:0] istrWordL;	// last accepted window, jumbo source

	logic [regWidth-1:0] decRegN, decRegM, decRegO;
	logic [immWidth-1:0] decImm, decImmB;
	logic [cmdWidth-1:0] decUCmd, decUIxt;
	lenWords             decLen;

	decOp i_decOp (
		.istrWord  (istrWord),
		.istrWordL (istrWordL),
		.idRegN    (decRegN),
		.idRegM    (decRegM),
		.idRegO    (decRegO),
		.idImm     (decImm),
		.idImmB    (decImmB),
		.idUCmd    (decUCmd),
		.idUIxt    (decUIxt),
		.idLen     (decLen)
	);

	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			opValid   <= 1'b0;
			istrWordL <= '0;	// no prefix seen yet
			opRegN    <= '0;
			opRegM    <= '0;
			opRegO    <= '0;
			opImm     <= '0;
			opImmB    <= '0;
			opUCmd    <= '0;
			opUIxt    <= '0;
			opLen     <= '0;
		end
		else
		begin
			opValid <= istrValid;
			if (istrValid)	// idle cycles leave prefix and outputs alone
			begin
				istrWordL <= istrWord;
				opRegN    <= decRegN;
				opRegM    <= decRegM;
				opRegO    <= decRegO;
				opImm     <= decImm;
				opImmB    <= decImmB;
				opUCmd    <= decUCmd;
				opUIxt    <= decUIxt;
				opLen     <= decLen;
			end
		end
	end

endmodule

`default_nettype wire

//--- tests/decodeModel.svh
// Decode reference model and LFSR
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

	localparam int resWidth = 3 * regWidth + 2 * immWidth + 2 * cmdWidth + 2;

	logic [15:0] lfsrState = 16'd97;

	// x^16 + x^14 + x^13 + x^11 + 1, one step per bit
	function automatic logic lfsrStep();
		logic fb;
		fb = lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10];
		lfsrState = {lfsrState[14:0], fb};
		return fb;
	endfunction

	function automatic logic [63:0] randBits(input int n);
		logic [63:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
			v = {v[62:0], lfsrStep()};
		return v;
	endfunction

	// packed as {regN, regM, regO, imm, immB, ucmd, ixt, len}
	function automatic logic [resWidth-1:0] decodeRef(input logic [63:0] w,
		input logic [63:0] last);
		logic [regWidth-1:0] rn, rm, ro;
		logic [immWidth-1:0] im, imb;
		logic [cmdWidth-1:0] uc, ix;
		logic [1:0]          ln;
		logic                pred, df, ja, jb;
		logic [23:0]         jlo, jhi;
		ja   = (last[15:8] == jumboTag);
		jb   = ja && (last[47:40] == jumboTag);
		jlo  = {last[7:0], last[31:16]};
		jhi  = {last[39:32], last[63:48]};
		pred = 1'b0;
		df   = 1'b0;
		ln   = 2'd1;
		if (w[15:11] == 5'b11100)
		begin
			ln   = 2'd2;
			pred = 1'b1;
			df   = w[10];
		end
		else if (w[15:10] == 6'b111010)
		begin
			ln   = 2'd2;
			pred = 1'b1;
			df   = w[8];
		end
		else if (w[15:10] == 6'b111011)
		begin
			ln   = 2'd3;
			pred = 1'b1;
			df   = w[9];
		end
		else if (w[15:11] == 5'b11110 || w[15:10] == 6'b111110)
			ln = 2'd2;
		else if (w[15:10] == 6'b111111)
			ln = 2'd3;
		imb = '0;
		if (ln == 2'd1)
		begin
			rn = {2'b00, w[11:8]};
			rm = {2'b00, w[7:4]};
			ro = '0;
			im = {{(immWidth-4){1'b0}}, w[3:0]};
			uc = {condAlways, grp16, w[15:12]};
			ix = '0;
		end
		else if (ln == 2'd2)
		begin
			rn  = w[21:16];
			rm  = w[27:22];
			ro  = {w[9:8], w[31:28]};
			im  = ja ? {jlo[23], jlo, w[31:24]} : {{(immWidth-10){w[31]}}, w[31:22]};
			imb = jb ? {1'b0, jhi, jlo[23:16]} : '0;
			uc  = {condAlways, grp32, w[3:0]};
			ix  = w[7:0];
		end
		else
		begin
			rn = w[21:16];
			rm = w[27:22];
			ro = '0;
			im = {{(immWidth-26){w[47]}}, w[47:22]};
			uc = {condAlways, grp48, w[3:0]};
			ix = {2'b00, w[9:4]};
		end
		if (pred)
			uc[7:6] = df ? condFalse : condTrue;
		if (ix[7:6] == ixtWideBad)
			uc[5:0] = ucmdInvop;
		return {rn, rm, ro, im, imb, uc, ix, ln};
	endfunction

`endif

//--- tests/decodeTb.sv
// Decode stage testbench
`timescale 1ns/1ps
`default_nettype none

module decodeTb import decodePkg::*;
();

	localparam int timeoutCycles = 200;

	logic                clock;
	logic                rst;
	logic                istrValid;
	logic [63:0]         istrWord;
	logic                opValid;
	logic [regWidth-1:0] opRegN, opRegM, opRegO;
	logic [immWidth-1:0] opImm, opImmB;
	logic [cmdWidth-1:0] opUCmd, opUIxt;
	lenWords             opLen;

	`include "decodeModel.svh"

	logic [resWidth-1:0] expQ[$];
	logic [resWidth-1:0] expCur;	// expected registered fields
	logic [resWidth-1:0] dutRes;
	logic [63:0]         modelLast;	// model copy of the last window
	int                  sentCnt = 0;
	int                  seenCnt = 0;

	decodeStage i_decodeStage (
		.clock     (clock),
		.rst       (rst),
		.istrValid (istrValid),
		.istrWord  (istrWord),
		.opValid   (opValid),
		.opRegN    (opRegN),
		.opRegM    (opRegM),
		.opRegO    (opRegO),
		.opImm     (opImm),
		.opImmB    (opImmB),
		.opUCmd    (opUCmd),
		.opUIxt    (opUIxt),
		.opLen     (opLen)
	);

	assign dutRes = {opRegN, opRegM, opRegO, opImm, opImmB, opUCmd, opUIxt, opLen};

	initial
	begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	// expected fields advance like the output registers
	always @(posedge clock)
	begin
		if (rst)
			expCur <= '0;
		else if (istrValid)
			expCur <= expQ.pop_front();
		if (!rst && opValid)
			seenCnt <= seenCnt + 1;
	end

	assert property (@(posedge clock) disable iff (rst) opValid == $past(istrValid))
	else
	begin
		$display("MISMATCH at %0t: opValid %b not one cycle behind istrValid", $time, opValid);
		$display("TEST FAILED");
		$fatal(1, "valid timing wrong");
	end

	assert property (@(posedge clock) disable iff (rst) opValid |-> (dutRes == expCur))
	else
	begin
		$display("MISMATCH at %0t: fields %h, expected %h", $time, dutRes, expCur);
		$display("TEST FAILED");
		$fatal(1, "decoded fields wrong");
	end

	// outputs hold while idle and read zero after reset
	assert property (@(posedge clock) disable iff (rst) !opValid |-> (dutRes == expCur))
	else
	begin
		$display("MISMATCH at %0t: idle fields %h, expected %h", $time, dutRes, expCur);
		$display("TEST FAILED");
		$fatal(1, "idle fields changed");
	end

	task automatic driveWindow(input logic [63:0] w);
		expQ.push_back(decodeRef(w, modelLast));
		modelLast = w;
		istrValid = 1'b1;
		istrWord  = w;
		@(posedge clock);
		#2;
		sentCnt++;
	endtask

	task automatic idleCycles(input int n);
		istrValid = 1'b0;
		istrWord  = 64'h1234_5678_9ABC_DEF0;	// ignored while idle
		repeat (n) @(posedge clock);
		#2;
	endtask

	function automatic logic [63:0] randomWindow();
		logic [63:0] w;
		logic [63:0] r;
		w = randBits(64);
		r = randBits(3);
		if (r[2:0] == 3'd0)
			w[15:8] = jumboTag;	// prefix A
		else if (r[2:0] == 3'd1)
		begin
			w[15:8]  = jumboTag;
			w[47:40] = jumboTag;
		end
		else if (r[2:0] < 3'd5)
			w[15:13] = 3'b111;	// lean on the long classes
		return w;
	endfunction

	initial
	begin
		int          waitCnt;
		logic [63:0] gap;
		rst       = 1'b1;
		istrValid = 1'b0;
		istrWord  = '0;
		modelLast = '0;
		repeat (4) @(posedge clock);
		#2;
		rst = 1'b0;
		idleCycles(3);

		// isolated short ops
		driveWindow(64'h0000_0000_0000_5A3C);
		idleCycles(2);
		driveWindow(64'h0000_0000_0000_12C7);
		idleCycles(1);

		// every class row back to back
		driveWindow(64'h0000_0000_7A51_E012);	// E0 with df clear
		driveWindow(64'h0000_0000_3C2D_E634);	// E4 with df set
		driveWindow(64'h0000_0000_8F3E_E856);	// E8 with df clear
		driveWindow(64'h0000_0000_4B19_E978);	// E9 with df set
		driveWindow(64'h0000_2468_ACE1_EC0A);
		driveWindow(64'h0000_F00D_1357_EE3B);	// EE with df set
		driveWindow(64'h0000_0000_6D4C_F10E);
		driveWindow(64'h0000_0000_9ABC_F5A1);
		driveWindow(64'h0000_0000_D2E3_FA3F);
		driveWindow(64'h0000_FFFF_C0DE_FD09);
		idleCycles(2);

		// extension pair 11 forces invalid op
		driveWindow(64'h0000_0000_1234_F0C5);
		driveWindow(64'h0000_0000_5678_E4D2);
		driveWindow(64'h0000_0000_9ABC_E8F0);
		driveWindow(64'h0000_0000_0F0F_FCC3);	// 48-bit never flags
		idleCycles(1);

		// jumbo prefixes
		driveWindow(64'h1111_2222_3344_FEA5);	// A only
		driveWindow(64'h0000_0000_9ABC_F123);
		driveWindow(64'hCDEF_FE89_3344_FE5A);	// A and B
		driveWindow(64'h0000_0000_1357_F246);
		driveWindow(64'hCDEF_FE89_3344_FE5A);
		driveWindow(64'h0000_0000_0000_4321);	// short op ignores prefix
		driveWindow(64'h0000_0000_3344_FE77);
		idleCycles(3);
		driveWindow(64'h0000_0000_8765_E201);	// prefix kept over idle gap
		idleCycles(2);

		for (int n = 0; n < 300; n++)
		begin
			driveWindow(randomWindow());
			gap = randBits(2);
			if (gap[1:0] == 2'b00)
				idleCycles(1);
		end
		idleCycles(1);

		waitCnt = 0;
		while (seenCnt < sentCnt && waitCnt < timeoutCycles)
		begin
			@(posedge clock);
			#2;
			waitCnt++;
		end
		if (seenCnt < sentCnt)
		begin
			$display("TEST FAILED");
			$fatal(1, "timed out waiting for %0d decoded results", sentCnt - seenCnt);
		end
		else
		begin
			$display("TEST OK");
			$finish;
		end
	end

endmodule

`default_nettype wire
